//--- all.f
+incdir+common
common/periph_pkg.sv
source/chip_select.sv
irq/irq_reg.sv
source/gpio_reg.sv
source/tick_timer.sv
source/periph_top.sv
test/tb_periph.sv

//--- Makefile
# Verilator build and run for the peripheral block
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/tb_periph.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_defines.svh"

module tb_periph
    import periph_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int ACK_WAIT   = 8;
    // five tests need about 1800 cycles at worst
    localparam int MAX_CYCLES = 4000;

    logic        wb_clk;
    logic        rst_n;
    logic [31:0] wb_dbus_adr;
    logic [31:0] wb_dbus_dat;
    logic        wb_dbus_we;
    logic        wb_dbus_cyc;
    logic        wb_dbus_ack;
    logic [31:0] wb_dbus_rdt;
    logic [7:0]  gpio_in;
    logic [7:0]  gpio_out;
    logic        irq;

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_errors_start;
    int          cycle_count;
    logic [31:0] lfsr_state;

    // reference model
    logic [7:0]  model_enable;
    logic [7:0]  model_pending;
    logic [7:0]  model_gpio_out;
    logic [7:0]  model_lines;

    periph_top u_dut (
        .wb_clk      (wb_clk),
        .rst_n       (rst_n),
        .wb_dbus_adr (wb_dbus_adr),
        .wb_dbus_dat (wb_dbus_dat),
        .wb_dbus_we  (wb_dbus_we),
        .wb_dbus_cyc (wb_dbus_cyc),
        .wb_dbus_ack (wb_dbus_ack),
        .wb_dbus_rdt (wb_dbus_rdt),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out),
        .irq         (irq)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge wb_clk);
            cycle_count++;
        end
        $display("run stopped: tests still busy after %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [7:0] base, input logic [2:0] idx);
        return {base, 19'h0, idx, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic start_test();
        test_errors_start = errors;
    endtask

    task automatic end_test(input string name);
        int failed_here;
        failed_here = errors - test_errors_start;
        tests_run++;
        if (failed_here == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, failed_here);
        end
    endtask

    // full four-phase exchange with rdata taken while ack is high
    task automatic bus_cycle(input logic [31:0] adr, input logic [31:0] dat, input logic we,
                             output logic [31:0] rdata, output logic acked);
        int waited;
        rdata = '0;
        acked = 1'b0;
        @(posedge wb_clk);
        wb_dbus_adr <= adr;
        wb_dbus_dat <= dat;
        wb_dbus_we  <= we;
        wb_dbus_cyc <= 1'b1;
        waited = 0;
        while (!acked && waited < ACK_WAIT) begin
            @(negedge wb_clk);
            waited++;
            if (wb_dbus_ack) begin
                acked = 1'b1;
                rdata = wb_dbus_rdt;
            end
        end
        @(posedge wb_clk);
        wb_dbus_cyc <= 1'b0;
        wb_dbus_we  <= 1'b0;
        waited = 0;
        do begin
            @(negedge wb_clk);
            waited++;
        end while (wb_dbus_ack && waited < ACK_WAIT);
        if (wb_dbus_ack) begin
            report_failure("acknowledge stayed high after cyc was dropped");
        end
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] unused_rd;
        logic        acked;
        bus_cycle(adr, dat, 1'b1, unused_rd, acked);
        if (!acked) begin
            report_failure("no acknowledge from the bus");
        end
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdata);
        logic acked;
        bus_cycle(adr, 32'h0, 1'b0, rdata, acked);
        if (!acked) begin
            report_failure("no acknowledge from the bus");
        end
    endtask

    // line 0 is the timer and stays low here while lines 7:1 follow the pins
    task automatic set_gpio(input logic [7:0] level);
        logic [7:0] lines_new;
        @(posedge wb_clk);
        gpio_in <= level;
        lines_new = {level[6:0], 1'b0};
        model_pending = model_pending | (lines_new & ~model_lines & model_enable);
        model_lines = lines_new;
    endtask

    task automatic wait_for_irq(input int limit, output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < limit) begin
            @(negedge wb_clk);
            n++;
            seen = irq;
        end
    endtask

    task automatic watch_irq(input int cycles, output logic seen);
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge wb_clk);
            if (irq) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic register_access();
        logic [31:0] rd;
        start_test();
        bus_write(reg_addr(`IRQ_BASE, IRQ_ENABLE), 32'h0000_00a5);
        model_enable = 8'ha5;
        bus_read(reg_addr(`IRQ_BASE, IRQ_ENABLE), rd);
        check_value("irq enable", rd, {24'h0, model_enable});
        bus_write(reg_addr(`IRQ_BASE, IRQ_SET_EN), 32'h0000_000a);
        model_enable = model_enable | 8'h0a;
        bus_read(reg_addr(`IRQ_BASE, IRQ_ENABLE), rd);
        check_value("irq enable after set", rd, {24'h0, model_enable});
        bus_write(reg_addr(`IRQ_BASE, IRQ_CLR_EN), 32'h0000_0021);
        model_enable = model_enable & ~8'h21;
        bus_read(reg_addr(`IRQ_BASE, IRQ_ENABLE), rd);
        check_value("irq enable after clear", rd, {24'h0, model_enable});
        bus_read(reg_addr(`IRQ_BASE, IRQ_CLEAR), rd);
        check_value("irq clear read", rd, 32'h0);
        bus_write(reg_addr(`GPIO_BASE, GPIO_OUT), 32'h0000_003c);
        model_gpio_out = 8'h3c;
        check_value("gpio_out", {24'h0, gpio_out}, {24'h0, model_gpio_out});
        bus_read(reg_addr(`GPIO_BASE, GPIO_OUT), rd);
        check_value("gpio out read", rd, {24'h0, model_gpio_out});
        bus_write(reg_addr(`IRQ_BASE, IRQ_ENABLE), 32'h0);
        model_enable = 8'h00;
        end_test("registers");
    endtask

    task automatic handshake_timing();
        logic [31:0] rd;
        logic        acked;
        start_test();
        @(posedge wb_clk);
        wb_dbus_adr <= reg_addr(`GPIO_BASE, GPIO_OUT);
        wb_dbus_we  <= 1'b0;
        @(negedge wb_clk);
        check_value("ack before cyc", 32'(wb_dbus_ack), 32'h0);
        check_value("rdt with ack low", wb_dbus_rdt, 32'h0);
        @(posedge wb_clk);
        wb_dbus_cyc <= 1'b1;
        @(negedge wb_clk);
        check_value("ack in cyc rise cycle", 32'(wb_dbus_ack), 32'h0);
        check_value("rdt with ack low", wb_dbus_rdt, 32'h0);
        @(negedge wb_clk);
        check_value("ack one cycle after cyc", 32'(wb_dbus_ack), 32'h1);
        check_value("rdt while ack", wb_dbus_rdt, {24'h0, model_gpio_out});
        repeat (3) begin
            @(negedge wb_clk);
            check_value("ack held with cyc", 32'(wb_dbus_ack), 32'h1);
        end
        @(posedge wb_clk);
        wb_dbus_cyc <= 1'b0;
        @(negedge wb_clk);
        check_value("ack at cyc drop", 32'(wb_dbus_ack), 32'h1);
        @(negedge wb_clk);
        check_value("ack one cycle after cyc drop", 32'(wb_dbus_ack), 32'h0);
        check_value("rdt with ack low", wb_dbus_rdt, 32'h0);
        // base 8'h90 selects no slave
        bus_cycle(reg_addr(8'h90, 3'd0), 32'h0, 1'b0, rd, acked);
        check_value("ack for unmapped address", 32'(acked), 32'h0);
        end_test("handshake");
    endtask

    task automatic gpio_interrupts();
        logic [31:0] rd;
        logic        seen;
        start_test();
        bus_write(reg_addr(`IRQ_BASE, IRQ_SET_EN), 32'h0000_0008);
        model_enable = model_enable | 8'h08;
        set_gpio(8'h04);
        wait_for_irq(6, seen);
        if (!seen) begin
            report_failure("irq did not rise within 6 cycles of gpio line 2");
        end
        bus_read(reg_addr(`IRQ_BASE, IRQ_STATE), rd);
        check_value("irq state", rd, {24'h0, model_pending});
        bus_read(reg_addr(`IRQ_BASE, IRQ_RAW), rd);
        check_value("irq raw", rd, {24'h0, model_lines});
        // pending and raw are both nonzero here
        bus_read(reg_addr(`IRQ_BASE, IRQ_CLEAR), rd);
        check_value("irq clear read with pending", rd, 32'h0);
        bus_read(reg_addr(`GPIO_BASE, GPIO_IN), rd);
        check_value("gpio in read", rd, 32'h0000_0004);
        bus_write(reg_addr(`IRQ_BASE, IRQ_CLEAR), 32'h0000_0008);
        model_pending = model_pending & ~8'h08;
        check_value("irq after clear", 32'(irq), 32'h0);
        // line 5 is not enabled
        set_gpio(8'h14);
        watch_irq(6, seen);
        check_value("irq for disabled line", 32'(seen), 32'h0);
        bus_read(reg_addr(`IRQ_BASE, IRQ_STATE), rd);
        check_value("irq state for disabled line", rd, {24'h0, model_pending});
        end_test("gpio interrupts");
    endtask

    task automatic timer_interrupt();
        logic [31:0] rd;
        logic        seen;
        start_test();
        bus_write(reg_addr(`TIMER_BASE, TIMER_PERIOD), 32'd20);
        bus_read(reg_addr(`TIMER_BASE, TIMER_PERIOD), rd);
        check_value("timer period", rd, 32'd20);
        bus_write(reg_addr(`IRQ_BASE, IRQ_SET_EN), 32'h0000_0001);
        model_enable = model_enable | 8'h01;
        bus_write(reg_addr(`TIMER_BASE, TIMER_CTRL), 32'h0000_0001);
        wait_for_irq(30, seen);
        if (!seen) begin
            report_failure("timer tick did not raise irq within 30 cycles");
        end
        bus_read(reg_addr(`IRQ_BASE, IRQ_STATE), rd);
        check_value("irq state bit 0", rd & 32'h1, 32'h1);
        bus_read(reg_addr(`TIMER_BASE, TIMER_COUNT), rd);
        check_value("timer count at most 20", 32'(rd <= 32'd20), 32'h1);
        bus_write(reg_addr(`TIMER_BASE, TIMER_CTRL), 32'h0);
        bus_write(reg_addr(`IRQ_BASE, IRQ_CLEAR), 32'h0000_0001);
        watch_irq(50, seen);
        check_value("irq with timer off", 32'(seen), 32'h0);
        end_test("timer interrupt");
    endtask

    task automatic random_enables();
        logic [31:0] rd;
        logic [1:0]  op;
        logic [7:0]  data;
        start_test();
        for (int i = 0; i < 40; i++) begin
            op = 2'(random_bits(2));
            data = 8'(random_bits(8));
            case (op)
                2'd0: begin
                    bus_write(reg_addr(`IRQ_BASE, IRQ_ENABLE), {24'h0, data});
                    model_enable = data;
                end
                2'd1: begin
                    bus_write(reg_addr(`IRQ_BASE, IRQ_SET_EN), {24'h0, data});
                    model_enable = model_enable | data;
                end
                2'd2: begin
                    bus_write(reg_addr(`IRQ_BASE, IRQ_CLR_EN), {24'h0, data});
                    model_enable = model_enable & ~data;
                end
                default: begin
                    bus_read(reg_addr(`IRQ_BASE, IRQ_ENABLE), rd);
                    check_value("irq enable", rd, {24'h0, model_enable});
                end
            endcase
        end
        for (int i = 0; i < 6; i++) begin
            set_gpio(8'(random_bits(8)));
            repeat (10) @(negedge wb_clk);
            bus_read(reg_addr(`IRQ_BASE, IRQ_STATE), rd);
            check_value("irq state", rd, {24'h0, model_pending});
            check_value("irq", 32'(irq), 32'(|(model_pending & model_enable)));
        end
        bus_write(reg_addr(`IRQ_BASE, IRQ_CLEAR), 32'h0000_00ff);
        model_pending = 8'h00;
        check_value("irq after clearing all", 32'(irq), 32'h0);
        end_test("random enable");
    endtask

    initial begin
        rst_n          = 1'b0;
        wb_dbus_adr    = '0;
        wb_dbus_dat    = '0;
        wb_dbus_we     = 1'b0;
        wb_dbus_cyc    = 1'b0;
        gpio_in        = '0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        lfsr_state     = 32'hed92_c2ce;
        model_enable   = 8'h00;
        model_pending  = 8'h00;
        model_gpio_out = 8'h00;
        model_lines    = 8'h00;
        repeat (2) @(posedge wb_clk);
        rst_n <= 1'b1;
        register_access();
        handshake_timing();
        gpio_interrupts();
        timer_interrupt();
        random_enables();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_defines.svh"

module periph_top (
    input  wire                wb_clk,
    input  wire                rst_n,
    input  wire [31:0]         wb_dbus_adr,
    input  wire [31:0]         wb_dbus_dat,
    input  wire                wb_dbus_we,
    input  wire                wb_dbus_cyc,
    output logic               wb_dbus_ack,
    output logic [31:0]        wb_dbus_rdt,
    input  wire [`GPIO_W-1:0]  gpio_in,
    output logic [`GPIO_W-1:0] gpio_out,
    output logic               irq
);

    logic                  irq_ack;
    logic                  gpio_ack;
    logic                  timer_ack;
    logic [31:0]           irq_rdt;
    logic [31:0]           gpio_rdt;
    logic [31:0]           timer_rdt;
    logic [`GPIO_W-1:0]    gpio_sync;
    logic                  timer_tick;
    logic [`IRQ_LINES-1:0] irq_lines;

    // line 0 is the timer, the rest come from the synchronized pins
    assign irq_lines = {gpio_sync[`IRQ_LINES-2:0], timer_tick};

    irq_reg #(
        .ADDR      (`IRQ_BASE),
        .ADDR_W    (`PERIPH_ADDR_W),
        .REG_WIDTH (`IRQ_LINES)
    ) u_irq (
        .wb_clk      (wb_clk),
        .rst_n       (rst_n),
        .wb_dbus_adr (wb_dbus_adr),
        .wb_dbus_dat (wb_dbus_dat),
        .wb_dbus_we  (wb_dbus_we),
        .wb_dbus_cyc (wb_dbus_cyc),
        .ack         (irq_ack),
        .rdt         (irq_rdt),
        .irq_in      (irq_lines),
        .irq         (irq)
    );

    gpio_reg #(
        .ADDR   (`GPIO_BASE),
        .ADDR_W (`PERIPH_ADDR_W),
        .WIDTH  (`GPIO_W)
    ) u_gpio (
        .wb_clk      (wb_clk),
        .rst_n       (rst_n),
        .wb_dbus_adr (wb_dbus_adr),
        .wb_dbus_dat (wb_dbus_dat),
        .wb_dbus_we  (wb_dbus_we),
        .wb_dbus_cyc (wb_dbus_cyc),
        .ack         (gpio_ack),
        .rdt         (gpio_rdt),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out),
        .gpio_sync   (gpio_sync)
    );

    tick_timer #(
        .ADDR   (`TIMER_BASE),
        .ADDR_W (`PERIPH_ADDR_W),
        .WIDTH  (`TIMER_W)
    ) u_timer (
        .wb_clk      (wb_clk),
        .rst_n       (rst_n),
        .wb_dbus_adr (wb_dbus_adr),
        .wb_dbus_dat (wb_dbus_dat),
        .wb_dbus_we  (wb_dbus_we),
        .wb_dbus_cyc (wb_dbus_cyc),
        .ack         (timer_ack),
        .rdt         (timer_rdt),
        .tick        (timer_tick)
    );

    // idle slaves drive zero, so a plain OR merges them
    assign wb_dbus_ack = irq_ack | gpio_ack | timer_ack;
    assign wb_dbus_rdt = irq_rdt | gpio_rdt | timer_rdt;

endmodule

`default_nettype wire

//--- source/tick_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tick_timer
    import periph_pkg::*;
#(
    parameter logic [7:0] ADDR   = 8'h00,
    parameter int         ADDR_W = 8,
    parameter int         WIDTH  = 16
) (
    input  wire         wb_clk,
    input  wire         rst_n,
    input  wire [31:0]  wb_dbus_adr,
    input  wire [31:0]  wb_dbus_dat,
    input  wire         wb_dbus_we,
    input  wire         wb_dbus_cyc,
    output logic        ack,
    output logic [31:0] rdt,
    output logic        tick
);

    logic             cyc;
    logic             wr;
    timer_reg_e       idx;
    logic [WIDTH-1:0] period;
    logic [WIDTH-1:0] count;
    logic             enable;
    logic [31:0]      rd_data;

    chip_select #(
        .ADDR   (ADDR),
        .ADDR_W (ADDR_W)
    ) u_cs (
        .wb_clk (wb_clk),
        .rst_n  (rst_n),
        .addr   (wb_dbus_adr[31:32-ADDR_W]),
        .wb_cyc (wb_dbus_cyc),
        .ack    (ack),
        .cyc    (cyc)
    );

    assign idx = timer_reg_e'(wb_dbus_adr[4:2]);
    assign wr  = cyc & wb_dbus_we;

    always_ff @(posedge wb_clk) begin
        if (!rst_n) begin
            period <= '0;
            enable <= 1'b0;
        end else if (wr) begin
            case (idx)
                TIMER_PERIOD: period <= wb_dbus_dat[WIDTH-1:0];
                TIMER_CTRL:   enable <= wb_dbus_dat[0];
                default: ;
            endcase
        end
    end

    // counts 0..period, tick lasts the cycle after the wrap
    always_ff @(posedge wb_clk) begin
        if (!rst_n || !enable) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == period) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

    always_ff @(posedge wb_clk) begin
        if (cyc) begin
            rd_data <= '0;
            if (!wb_dbus_we) begin
                case (idx)
                    TIMER_PERIOD: rd_data <= 32'(period);
                    TIMER_COUNT:  rd_data <= 32'(count);
                    TIMER_CTRL:   rd_data <= {31'h0, enable};
                    default:      rd_data <= '0;
                endcase
            end
        end
    end

    assign rdt = ack ? rd_data : 32'h0;

endmodule

`default_nettype wire

//--- source/gpio_reg.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_reg
    import periph_pkg::*;
#(
    parameter logic [7:0] ADDR   = 8'h00,
    parameter int         ADDR_W = 8,
    parameter int         WIDTH  = 8
) (
    input  wire              wb_clk,
    input  wire              rst_n,
    input  wire [31:0]       wb_dbus_adr,
    input  wire [31:0]       wb_dbus_dat,
    input  wire              wb_dbus_we,
    input  wire              wb_dbus_cyc,
    output logic             ack,
    output logic [31:0]      rdt,
    input  wire [WIDTH-1:0]  gpio_in,
    output logic [WIDTH-1:0] gpio_out,
    output logic [WIDTH-1:0] gpio_sync
);

    logic             cyc;
    gpio_reg_e        idx;
    logic [WIDTH-1:0] sync_q1;
    logic [WIDTH-1:0] sync_q2;
    logic [31:0]      rd_data;

    chip_select #(
        .ADDR   (ADDR),
        .ADDR_W (ADDR_W)
    ) u_cs (
        .wb_clk (wb_clk),
        .rst_n  (rst_n),
        .addr   (wb_dbus_adr[31:32-ADDR_W]),
        .wb_cyc (wb_dbus_cyc),
        .ack    (ack),
        .cyc    (cyc)
    );

    assign idx = gpio_reg_e'(wb_dbus_adr[4:2]);

    // two-flop synchronizer on the pins
    always_ff @(posedge wb_clk) begin
        if (!rst_n) begin
            sync_q1  <= '0;
            sync_q2  <= '0;
            gpio_out <= '0;
        end else begin
            sync_q1 <= gpio_in;
            sync_q2 <= sync_q1;
            if (cyc && wb_dbus_we && idx == GPIO_OUT) begin
                gpio_out <= wb_dbus_dat[WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge wb_clk) begin
        if (cyc) begin
            rd_data <= '0;
            if (!wb_dbus_we) begin
                case (idx)
                    GPIO_OUT: rd_data <= 32'(gpio_out);
                    GPIO_IN:  rd_data <= 32'(sync_q2);
                    default:  rd_data <= '0;
                endcase
            end
        end
    end

    assign gpio_sync = sync_q2;
    assign rdt       = ack ? rd_data : 32'h0;

endmodule

`default_nettype wire

//--- irq/irq_reg.sv
`timescale 1ns/1ps
`default_nettype none

module irq_reg
    import periph_pkg::*;
#(
    parameter logic [7:0] ADDR      = 8'h00,
    parameter int         ADDR_W    = 8,
    parameter int         REG_WIDTH = 8
) (
    input  wire                 wb_clk,
    input  wire                 rst_n,
    input  wire [31:0]          wb_dbus_adr,
    input  wire [31:0]          wb_dbus_dat,
    input  wire                 wb_dbus_we,
    input  wire                 wb_dbus_cyc,
    output logic                ack,
    output logic [31:0]         rdt,
    input  wire [REG_WIDTH-1:0] irq_in,
    output logic                irq
);

    logic                 cyc;
    logic                 wr;
    irq_reg_e             idx;
    logic [REG_WIDTH-1:0] wdata;
    logic [REG_WIDTH-1:0] enable_reg;
    logic [REG_WIDTH-1:0] state_reg;
    logic [REG_WIDTH-1:0] prev_reg;
    logic [REG_WIDTH-1:0] irq_detect;
    logic [REG_WIDTH-1:0] clear_mask;
    logic [31:0]          rd_data;

    chip_select #(
        .ADDR   (ADDR),
        .ADDR_W (ADDR_W)
    ) u_cs (
        .wb_clk (wb_clk),
        .rst_n  (rst_n),
        .addr   (wb_dbus_adr[31:32-ADDR_W]),
        .wb_cyc (wb_dbus_cyc),
        .ack    (ack),
        .cyc    (cyc)
    );

    assign idx   = irq_reg_e'(wb_dbus_adr[4:2]);
    assign wr    = cyc & wb_dbus_we;
    assign wdata = wb_dbus_dat[REG_WIDTH-1:0];

    // rising edges since the previous clock
    assign irq_detect = irq_in & ~prev_reg;
    assign clear_mask = (wr && idx == IRQ_CLEAR) ? wdata : '0;

    always_ff @(posedge wb_clk) begin
        if (!rst_n) begin
            enable_reg <= '0;
            state_reg  <= '0;
            prev_reg   <= '0;
        end else begin
            prev_reg <= irq_in;
            // set after clear, so a new edge survives a clear of the same line
            state_reg <= (state_reg & ~clear_mask) | (enable_reg & irq_detect);
            if (wr) begin
                case (idx)
                    IRQ_ENABLE: enable_reg <= wdata;
                    IRQ_SET_EN: enable_reg <= enable_reg | wdata;
                    IRQ_CLR_EN: enable_reg <= enable_reg & ~wdata;
                    default: ;
                endcase
            end
        end
    end

    // read data captured at the strobe, writes return zero
    always_ff @(posedge wb_clk) begin
        if (cyc) begin
            rd_data <= '0;
            if (!wb_dbus_we) begin
                case (idx)
                    IRQ_ENABLE: rd_data <= 32'(enable_reg);
                    IRQ_STATE:  rd_data <= 32'(state_reg);
                    IRQ_RAW:    rd_data <= 32'(irq_in);
                    default:    rd_data <= '0;
                endcase
            end
        end
    end

    assign rdt = ack ? rd_data : 32'h0;
    assign irq = |(state_reg & enable_reg);

endmodule

`default_nettype wire

//--- source/chip_select.sv
`timescale 1ns/1ps
`default_nettype none

module chip_select #(
    parameter logic [7:0] ADDR   = 8'h00,
    parameter int         ADDR_W = 8
) (
    input  wire              wb_clk,
    input  wire              rst_n,
    input  wire [ADDR_W-1:0] addr,
    input  wire              wb_cyc,
    output logic             ack,
    output logic             cyc
);

    logic match;

    assign match = (addr == ADDR[ADDR_W-1:0]);

    // one strobe per exchange: ack holds until cyc is dropped
    assign cyc = wb_cyc & match & ~ack;

    always_ff @(posedge wb_clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (!wb_cyc) begin
            // four-phase release, ack follows cyc down
            ack <= 1'b0;
        end else if (cyc) begin
            ack <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- common/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // interrupt controller word index, address bits 4:2
    typedef enum logic [2:0] {
        IRQ_ENABLE = 3'd0,
        IRQ_STATE  = 3'd1,
        IRQ_CLEAR  = 3'd2,
        IRQ_RAW    = 3'd3,
        IRQ_SET_EN = 3'd4,
        IRQ_CLR_EN = 3'd5
    } irq_reg_e;

    // gpio word index
    typedef enum logic [2:0] {
        GPIO_OUT = 3'd0,
        GPIO_IN  = 3'd1
    } gpio_reg_e;

    // timer word index, ctrl bit 0 is enable
    typedef enum logic [2:0] {
        TIMER_PERIOD = 3'd0,
        TIMER_COUNT  = 3'd1,
        TIMER_CTRL   = 3'd2
    } timer_reg_e;

endpackage

`default_nettype wire

//--- common/periph_defines.svh
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// top address bits compared by each slave decoder
`define PERIPH_ADDR_W 8

// slave selects for address bits 31:24
`define IRQ_BASE      8'h80
`define GPIO_BASE     8'h81
`define TIMER_BASE    8'h82

// interrupt controller width
`define IRQ_LINES     8

// gpio port width
`define GPIO_W        8

// timer counter width
`define TIMER_W       16

`endif
